// ==== sim/sram_vectors.txt ====
// grp_acs_awe_aadr_adat_bcs_bwe_badr_bdat_mask_expa_expb, cs nibble is cyc in bit1, stb in bit0
// mask bit0 checks a_dat_o and bit1 checks b_dat_o against expa and expb on the next cycle
0_2_0_000_00000000_1_0_000_00_0_00000000_00
0_3_0_005_00000000_3_0_123_00_3_00000000_00
1_3_1_010_89abcdef_0_0_000_00_0_00000000_00
1_3_0_010_00000000_3_0_040_00_3_89abcdef_ef
1_0_0_000_00000000_3_0_041_00_2_00000000_cd
1_0_0_000_00000000_3_0_042_00_2_00000000_ab
1_0_0_000_00000000_3_0_043_00_2_00000000_89
2_0_0_000_00000000_3_1_080_11_0_00000000_00
2_0_0_000_00000000_3_1_081_22_0_00000000_00
2_0_0_000_00000000_3_1_082_33_0_00000000_00
2_0_0_000_00000000_3_1_083_44_0_00000000_00
2_3_0_020_00000000_0_0_000_00_1_44332211_00
3_3_1_030_cafef00d_3_0_0c1_00_3_00000000_00
3_3_0_030_00000000_3_0_0c1_00_3_cafef00d_f0
3_3_0_030_00000000_3_1_0c0_5a_3_cafef00d_0d
3_3_0_030_00000000_3_0_0c0_00_3_cafef05a_5a
4_3_1_040_01020304_3_1_102_ee_3_00000000_00
4_3_0_040_00000000_3_0_102_00_3_01020304_02
5_3_1_050_a5a5a5a5_3_1_144_3c_3_00000000_00
5_3_0_051_00000000_3_0_143_00_3_0000003c_a5
5_3_1_051_12345678_3_0_144_00_3_0000003c_3c
5_3_0_050_00000000_3_0_147_00_3_a5a5a5a5_12
5_3_0_051_00000000_3_1_140_99_3_12345678_a5
5_3_0_050_00000000_3_0_140_00_3_a5a5a599_99

// ==== sim.f ====
design/sram_pkg.sv
design/sram_port_decode.sv
design/byte_lane_bank.sv
design/sram_read_merge.sv
design/wb_sram_dual_port.sv
sim/tb_sram.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_sram
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_sram.sv ====
module tb_sram
   import sram_pkg::*;
();

   localparam int NVEC      = 24;                     // lines in the vector file
   localparam int RESET_CYC = 10;
   localparam int LIMIT     = NVEC + RESET_CYC + 20;  // cycle budget for the whole run

   // DUT side
   logic                    a_clk_i;
   logic                    rst_i;
   logic                    a_cyc_i, a_stb_i, a_we_i;
   logic [A_AW-1:0]         a_adr_i;
   logic [LANES*LANE_W-1:0] a_dat_i;
   logic                    a_ack_o;
   logic [LANES*LANE_W-1:0] a_dat_o;
   logic                    b_cyc_i, b_stb_i, b_we_i;
   logic [B_AW-1:0]         b_adr_i;
   logic [LANE_W-1:0]       b_dat_i;
   logic                    b_ack_o;
   logic [LANE_W-1:0]       b_dat_o;

   // one 128-bit vector per cycle as laid out in sim/sram_vectors.txt
   logic [127:0] vec [NVEC];

   int cycles;
   int grp_checks, grp_errors;     // running counts of the current test
   int tests_pass, tests_fail;
   bit load_err;

   wb_sram_dual_port DUT (
      .a_clk_i (a_clk_i),
      .rst_i   (rst_i),
      .a_cyc_i (a_cyc_i),
      .a_stb_i (a_stb_i),
      .a_we_i  (a_we_i),
      .a_adr_i (a_adr_i),
      .a_dat_i (a_dat_i),
      .a_ack_o (a_ack_o),
      .a_dat_o (a_dat_o),
      .b_cyc_i (b_cyc_i),
      .b_stb_i (b_stb_i),
      .b_we_i  (b_we_i),
      .b_adr_i (b_adr_i),
      .b_dat_i (b_dat_i),
      .b_ack_o (b_ack_o),
      .b_dat_o (b_dat_o)
   );

   // --------------------
   // clock and timeout
   // --------------------
   initial begin
      a_clk_i = 1'b0;
      forever #50 a_clk_i = ~a_clk_i;  // period 100
   end

   initial begin
      cycles = 0;
      while (cycles < LIMIT) begin
         @(posedge a_clk_i);
         cycles++;
      end
      $display("timeout: run still going after %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
   end

   // --------------------
   // helpers
   // --------------------
   function automatic string test_name(input logic [3:0] grp);
      case (grp)
         4'd0:    return "reset_state";
         4'd1:    return "word_byte_views";
         4'd2:    return "byte_assembly";
         4'd3:    return "read_first";
         4'd4:    return "collision";
         4'd5:    return "pipelining";
         default: return "unknown";
      endcase
   endfunction

   // field slices follow the nibble columns of the vector file
   task automatic apply_vector(input logic [127:0] v);
      a_cyc_i <= v[121];         // cyc in bit1 and stb in bit0 of the cs nibble
      a_stb_i <= v[120];
      a_we_i  <= v[116];
      a_adr_i <= v[113:104];
      a_dat_i <= v[103:72];
      b_cyc_i <= v[69];
      b_stb_i <= v[68];
      b_we_i  <= v[64];
      b_adr_i <= v[63:52];
      b_dat_i <= v[51:44];
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      grp_checks++;
      if (actual !== expected) begin
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
         grp_errors++;
      end
   endtask

   // first cycle out of reset, no request seen yet
   task automatic check_reset_outputs();
      check_value("reset_state a_ack", 32'd0, 32'(a_ack_o));
      check_value("reset_state b_ack", 32'd0, 32'(b_ack_o));
      check_value("reset_state a_dat", 32'd0, a_dat_o);   // read registers cleared
      check_value("reset_state b_dat", 32'd0, 32'(b_dat_o));
   endtask

   // responses to vector v one cycle after it was driven
   task automatic check_response(input logic [127:0] v);
      string tname;
      tname = test_name(v[127:124]);
      check_value({tname, " a_ack"}, 32'(v[121] & v[120]), 32'(a_ack_o));  // cyc and stb
      check_value({tname, " b_ack"}, 32'(v[69] & v[68]), 32'(b_ack_o));
      if (v[40]) check_value({tname, " a_dat"}, v[39:8], a_dat_o);
      if (v[41]) check_value({tname, " b_dat"}, 32'(v[7:0]), 32'(b_dat_o));
   endtask

   task automatic finish_test(input logic [3:0] grp);
      if (grp_errors == 0) tests_pass++;
      else tests_fail++;
      $display("test %-16s %0d checks, %0d errors", test_name(grp), grp_checks, grp_errors);
      grp_checks = 0;
      grp_errors = 0;
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      rst_i <= 1'b1;
      apply_vector('0);              // all ports idle
      grp_checks = 0;
      grp_errors = 0;
      tests_pass = 0;
      tests_fail = 0;
      load_err   = 1'b0;
      $readmemh("sim/sram_vectors.txt", vec);
      if ($isunknown(vec[NVEC-1])) begin
         $display("vector file sim/sram_vectors.txt is missing or short");
         load_err = 1'b1;
      end
      repeat (RESET_CYC) @(posedge a_clk_i);
      rst_i <= 1'b0;

      for (int i = 0; i <= NVEC; i++) begin
         @(posedge a_clk_i);
         if (i < NVEC) apply_vector(vec[i]);
         else apply_vector('0);       // drain the last response
         @(negedge a_clk_i);          // outputs settled mid-cycle
         if (i == 0) begin
            check_reset_outputs();
         end else begin
            check_response(vec[i-1]);
            if (i == NVEC) finish_test(vec[i-1][127:124]);
            else if (vec[i][127:124] != vec[i-1][127:124]) finish_test(vec[i-1][127:124]);
         end
      end

      $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
      if (tests_fail == 0 && !load_err) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== design/wb_sram_dual_port.sv ====
module wb_sram_dual_port
   import sram_pkg::*;
(
   input  logic                      a_clk_i,
   input  logic                      rst_i,
   // port A, 32-bit word bus
   input  logic                      a_cyc_i,
   input  logic                      a_stb_i,
   input  logic                      a_we_i,
   input  word_adr_t                 a_adr_i,
   input  logic [LANES*LANE_W-1:0]   a_dat_i,
   output logic                      a_ack_o,
   output logic [LANES*LANE_W-1:0]   a_dat_o,
   // port B, 8-bit byte bus
   input  logic                      b_cyc_i,
   input  logic                      b_stb_i,
   input  logic                      b_we_i,
   input  byte_adr_t                 b_adr_i,
   input  logic [LANE_W-1:0]         b_dat_i,
   output logic                      b_ack_o,
   output logic [LANE_W-1:0]         b_dat_o
);

   // decoder to banks
   logic [LANES-1:0]        lane_a_en, lane_a_we;
   logic [LANES-1:0]        lane_b_en, lane_b_we;
   word_adr_t               lane_a_adr, lane_b_adr;
   logic [LANES*LANE_W-1:0] lane_a_dat;
   logic [LANE_W-1:0]       lane_b_dat;
   // decoder to merger
   logic                    a_req, b_req;
   lane_sel_t               b_lane;
   // banks to merger
   logic [LANES*LANE_W-1:0] lane_a_q, lane_b_q;

   sram_port_decode u_decode (
      .a_cyc_i      (a_cyc_i),
      .a_stb_i      (a_stb_i),
      .a_we_i       (a_we_i),
      .a_adr_i      (a_adr_i),
      .a_dat_i      (a_dat_i),
      .b_cyc_i      (b_cyc_i),
      .b_stb_i      (b_stb_i),
      .b_we_i       (b_we_i),
      .b_adr_i      (b_adr_i),
      .b_dat_i      (b_dat_i),
      .lane_a_en_o  (lane_a_en),
      .lane_a_we_o  (lane_a_we),
      .lane_b_en_o  (lane_b_en),
      .lane_b_we_o  (lane_b_we),
      .lane_a_adr_o (lane_a_adr),
      .lane_b_adr_o (lane_b_adr),
      .lane_a_dat_o (lane_a_dat),
      .lane_b_dat_o (lane_b_dat),
      .a_req_o      (a_req),
      .b_req_o      (b_req),
      .b_lane_o     (b_lane)
   );

   // --------------------
   // byte lane banks
   // --------------------
   for (genvar l = 0; l < LANES; l++) begin : g_lane
      byte_lane_bank u_bank (
         .a_clk_i (a_clk_i),
         .rst_i   (rst_i),
         .a_en_i  (lane_a_en[l]),
         .a_we_i  (lane_a_we[l]),
         .a_adr_i (lane_a_adr),
         .a_dat_i (lane_a_dat[l*LANE_W +: LANE_W]),  // byte l of the word
         .b_en_i  (lane_b_en[l]),
         .b_we_i  (lane_b_we[l]),
         .b_adr_i (lane_b_adr),
         .b_dat_i (lane_b_dat),                      // shared, en picks the lane
         .a_q_o   (lane_a_q[l*LANE_W +: LANE_W]),
         .b_q_o   (lane_b_q[l*LANE_W +: LANE_W])
      );
   end

   sram_read_merge u_merge (
      .a_clk_i    (a_clk_i),
      .rst_i      (rst_i),
      .a_req_i    (a_req),
      .b_req_i    (b_req),
      .b_lane_i   (b_lane),
      .lane_a_q_i (lane_a_q),
      .lane_b_q_i (lane_b_q),
      .a_ack_o    (a_ack_o),
      .a_dat_o    (a_dat_o),
      .b_ack_o    (b_ack_o),
      .b_dat_o    (b_dat_o)
   );

endmodule

// ==== design/sram_read_merge.sv ====
module sram_read_merge
   import sram_pkg::*;
(
   input  logic                      a_clk_i,
   input  logic                      rst_i,
   // request strobes from the decoder
   input  logic                      a_req_i,
   input  logic                      b_req_i,
   input  lane_sel_t                 b_lane_i,
   // registered bytes from the banks
   input  logic [LANES*LANE_W-1:0]   lane_a_q_i,  // side A, lane l at byte l
   input  logic [LANES*LANE_W-1:0]   lane_b_q_i,  // side B, lane l at byte l
   // bus outputs
   output logic                      a_ack_o,
   output logic [LANES*LANE_W-1:0]   a_dat_o,
   output logic                      b_ack_o,
   output logic [LANE_W-1:0]         b_dat_o
);

   lane_sel_t b_lane_q;   // lane of the last port-B request

   // --------------------
   // acknowledge pipeline
   // --------------------
   // one ack per strobe, always the next cycle, no wait states
   always_ff @(posedge a_clk_i) begin
      if (rst_i) begin
         a_ack_o  <= 1'b0;
         b_ack_o  <= 1'b0;
         b_lane_q <= '0;
      end else begin
         a_ack_o <= a_req_i;
         b_ack_o <= b_req_i;
         if (b_req_i) b_lane_q <= b_lane_i;  // follows the bank register hold
      end
   end

   // --------------------
   // data assembly
   // --------------------

   // lane 3 is the high byte of the word
   always_comb begin
      for (int l = 0; l < LANES; l++) begin
         a_dat_o[l*LANE_W +: LANE_W] = lane_a_q_i[l*LANE_W +: LANE_W];
      end
   end

   // only the lane that port B addressed holds a fresh side-B byte
   assign b_dat_o = lane_b_q_i[int'(b_lane_q)*LANE_W +: LANE_W];

endmodule

// ==== design/byte_lane_bank.sv ====
module byte_lane_bank
   import sram_pkg::*;
(
   input  logic              a_clk_i,
   input  logic              rst_i,
   // side A
   input  logic              a_en_i,
   input  logic              a_we_i,
   input  word_adr_t         a_adr_i,
   input  logic [LANE_W-1:0] a_dat_i,
   // side B
   input  logic              b_en_i,
   input  logic              b_we_i,
   input  word_adr_t         b_adr_i,
   input  logic [LANE_W-1:0] b_dat_i,
   // registered read bytes
   output logic [LANE_W-1:0] a_q_o,
   output logic [LANE_W-1:0] b_q_o
);

   // one byte of every word, cleared at start of simulation
   logic [LANE_W-1:0] mem [WORDS] = '{default: '0};

   // --------------------
   // storage writes
   // --------------------
   // the decoder never lets both sides write the same address in one cycle
   always_ff @(posedge a_clk_i) begin
      if (a_en_i && a_we_i) mem[a_adr_i] <= a_dat_i;
      if (b_en_i && b_we_i) mem[b_adr_i] <= b_dat_i;
   end

   // --------------------
   // read registers
   // --------------------
   // sampled before this edge's writes land, hence read-first
   always_ff @(posedge a_clk_i) begin
      if (rst_i) begin
         a_q_o <= '0;
         b_q_o <= '0;
      end else begin
         if (a_en_i) a_q_o <= mem[a_adr_i];  // hold when idle
         if (b_en_i) b_q_o <= mem[b_adr_i];
      end
   end

endmodule

// ==== design/sram_port_decode.sv ====
module sram_port_decode
   import sram_pkg::*;
(
   // port A, word side
   input  logic                      a_cyc_i,
   input  logic                      a_stb_i,
   input  logic                      a_we_i,
   input  word_adr_t                 a_adr_i,
   input  logic [LANES*LANE_W-1:0]   a_dat_i,
   // port B, byte side
   input  logic                      b_cyc_i,
   input  logic                      b_stb_i,
   input  logic                      b_we_i,
   input  byte_adr_t                 b_adr_i,
   input  logic [LANE_W-1:0]         b_dat_i,
   // per-lane controls, side A
   output logic [LANES-1:0]          lane_a_en_o,
   output logic [LANES-1:0]          lane_a_we_o,
   output word_adr_t                 lane_a_adr_o,
   output logic [LANES*LANE_W-1:0]   lane_a_dat_o,  // one byte per lane
   // per-lane controls, side B
   output logic [LANES-1:0]          lane_b_en_o,
   output logic [LANES-1:0]          lane_b_we_o,
   output word_adr_t                 lane_b_adr_o,
   output logic [LANE_W-1:0]         lane_b_dat_o,  // same byte to every lane
   // to the read merger
   output logic                      a_req_o,
   output logic                      b_req_o,
   output lane_sel_t                 b_lane_o
);

   logic      a_req;      // port A strobe this cycle
   logic      b_req;      // port B strobe this cycle
   word_adr_t b_word;     // port-B word part
   lane_sel_t b_lane;     // port-B byte part
   logic      collide;    // both ports writing the same word

   // --------------------
   // request and address split
   // --------------------
   assign a_req  = a_cyc_i & a_stb_i;
   assign b_req  = b_cyc_i & b_stb_i;
   assign b_word = b_adr_i[B_AW-1:$clog2(LANES)];  // upper bits pick the word
   assign b_lane = b_adr_i[$clog2(LANES)-1:0];     // low bits pick the byte

   // port A always writes every lane, so same word means same byte for B
   assign collide = a_req & a_we_i & b_req & b_we_i & (a_adr_i == b_word);

   // --------------------
   // lane enables
   // --------------------
   always_comb begin
      lane_a_en_o = {LANES{a_req}};           // A touches the whole word
      lane_a_we_o = {LANES{a_req & a_we_i}};
      lane_b_en_o = '0;
      lane_b_we_o = '0;
      if (b_req) begin
         lane_b_en_o[b_lane] = 1'b1;          // only the addressed byte
         lane_b_we_o[b_lane] = b_we_i & ~collide;  // A wins, B write dropped
      end
   end

   // addresses and data fan out to all banks
   assign lane_a_adr_o = a_adr_i;
   assign lane_a_dat_o = a_dat_i;              // byte l goes to lane l
   assign lane_b_adr_o = b_word;
   assign lane_b_dat_o = b_dat_i;

   assign a_req_o  = a_req;
   assign b_req_o  = b_req;
   assign b_lane_o = b_lane;                   // merger registers this

endmodule

// ==== design/sram_pkg.sv ====
package sram_pkg;

   // --------------------
   // array geometry
   // --------------------
   localparam int SBITS  = 10;          // word address bits
   localparam int WORDS  = 1 << SBITS;  // depth of every lane bank
   localparam int LANES  = 4;           // byte lanes per word
   localparam int LANE_W = 8;           // bits per lane

   // --------------------
   // port address widths
   // --------------------

   // port A addresses whole words
   localparam int A_AW = SBITS;

   // port B adds the byte index below the word address
   localparam int B_AW = SBITS + $clog2(LANES);

   // --------------------
   // shared types
   // --------------------
   typedef logic [A_AW-1:0]          word_adr_t;  // word index, also bank address
   typedef logic [B_AW-1:0]          byte_adr_t;  // port-B byte address
   typedef logic [$clog2(LANES)-1:0] lane_sel_t;  // byte within a word, 0 = low byte

   // byte address layout seen by port B:
   //   [B_AW-1:$clog2(LANES)]  word address
   //   [$clog2(LANES)-1:0]     lane select
   // so byte address = word * LANES + lane, little-endian within the word

endpackage
